// File: sim/tb_cft_input.txt
# T test_name | P hex_addr hex_word (deposit) | E hex_word (next expected out_data)
T ldi_sta_add_wrap
P 000 1FFF
P 001 3100
P 002 4101
P 003 A000
P 004 2100
P 005 A000
P 006 0000
P 101 F002
E 0001
E 0FFF
T rerun_and_not
P 000 4100
P 001 5101
P 002 A000
P 003 6000
P 004 A000
P 005 0000
P 100 F0F0
P 101 3C3C
E 3030
E CFCF
T jz_countdown_jmp
P 000 1003
P 001 A000
P 002 4100
P 003 8005
P 004 7001
P 005 7007
P 006 A000
P 007 0000
P 100 FFFF
E 0003
E 0002
E 0001
T jn_countdown_burst
P 000 1001
P 001 A000
P 002 A000
P 003 4100
P 004 9006
P 005 7001
P 006 0000
P 100 FFFF
E 0001
E 0001
E 0000
E 0000

// File: all.f
src/cft_pkg.sv
src/card_ctl.sv
src/card_reg.sv
src/card_alu.sv
src/card_mem.sv
src/card_bus.sv
src/cft_mini.sv
sim/tb_cft.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cft -f all.f -o tb_cft \
   || { echo "build failed"; exit 1; }
result="$(./obj_dir/tb_cft 2>&1)"
echo "$result"
echo "$result" | grep -qx "sim passed" && exit 0 || exit 1

// File: sim/tb_cft.sv
`timescale 1ns/100ps

module tb_cft;

   localparam int HALF_PERIOD = 20;                    // 40 ns clock
   localparam int CREDITS     = 2;                     // Receiver buffer depth
   localparam int LINE_CYCLES = 12;                    // Watchdog budget per data line
   localparam int SLACK       = 200;

   logic                       clk = 1'b0;
   logic                       arst_n;
   logic                       fp_we;
   logic [cft_pkg::ADDR_W-1:0] fp_addr;
   logic [cft_pkg::DATA_W-1:0] fp_data;
   logic                       start;
   logic                       halted;
   logic                       out_valid;
   logic [cft_pkg::DATA_W-1:0] out_data;
   logic                       out_credit = 1'b0;      // Driven by the receiver

   string test_name = "reset";
   string name_q[$];                                   // One per T line
   int    p_lo_q[$];                                   // First deposit of each test
   int    e_lo_q[$];                                   // First expected word of each test
   int    p_addr_q[$];
   int    p_data_q[$];
   int    exp_q[$];
   int    due_q[$];                                    // Cycle of each pending credit
   int    e_ptr = 0;                                   // Next expected word
   int    e_end = 0;                                   // Stop mark of current test
   int    outstanding = 0;                             // Words not yet credited
   int    cyc = 0;
   int    limit = 0;

   cft_mini UUT (
      .clk(clk), .arst_n(arst_n), .fp_we(fp_we), .fp_addr(fp_addr), .fp_data(fp_data),
      .start(start), .halted(halted), .out_valid(out_valid), .out_data(out_data),
      .out_credit(out_credit)
   );

   always #HALF_PERIOD clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string what, input int expected, input int actual);
      if (expected != actual) begin
         stop_run($sformatf("error %s %s expected %0h actual %0h",
                            test_name, what, expected, actual));
      end
   endtask

   task automatic read_tests();
      int    fd;
      int    addr;
      int    word;
      string line;
      string name;
      fd = $fopen("sim/tb_cft_input.txt", "r");
      if (fd == 0) stop_run("could not open sim/tb_cft_input.txt");
      while ($fgets(line, fd) != 0) begin
         case (line.getc(0))
            "T": begin
               void'($sscanf(line, "T %s", name));
               name_q.push_back(name);
               p_lo_q.push_back(p_addr_q.size());
               e_lo_q.push_back(exp_q.size());
            end
            "P": begin
               void'($sscanf(line, "P %h %h", addr, word));
               p_addr_q.push_back(addr);
               p_data_q.push_back(word);
            end
            "E": begin
               void'($sscanf(line, "E %h", word));
               exp_q.push_back(word);
            end
            default: ;                                 // Comment or blank
         endcase
      end
      $fclose(fd);
      p_lo_q.push_back(p_addr_q.size());               // Close the last test
      e_lo_q.push_back(exp_q.size());
   endtask

   //////////////////////////////////////////////////
   // Output receiver with late random credit returns
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      cyc = cyc + 1;
      out_credit <= 1'b0;
      if (out_valid === 1'b1) begin
         if (outstanding >= CREDITS) stop_run("out_valid fired with no credit left");
         if (e_ptr >= e_end) stop_run($sformatf("test %s sent an extra word", test_name));
         check_value("out_data", exp_q[e_ptr], int'(out_data));
         e_ptr = e_ptr + 1;
         outstanding = outstanding + 1;
         due_q.push_back(cyc + int'($urandom % 9));    // 0 to 8 cycles late
      end
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
         void'(due_q.pop_front());
         out_credit <= 1'b1;                           // One credit per cycle
         outstanding = outstanding - 1;
      end
   end

   // Watchdog armed once the test list is known
   initial begin
      wait (limit != 0);
      repeat (limit) @(posedge clk);
      stop_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(32'hc6ae_63b1));                  // Single seed for the run
      arst_n  = 1'b0;
      fp_we   = 1'b0;
      fp_addr = '0;
      fp_data = '0;
      start   = 1'b0;
      read_tests();
      limit = (p_addr_q.size() + exp_q.size()) * LINE_CYCLES + SLACK;
      repeat (3) @(posedge clk);                       // Reset over 3 cycles
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("halted after reset", 1, int'(halted));
      check_value("out_valid after reset", 0, int'(out_valid));
      for (int t = 0; t < name_q.size(); t++) begin
         test_name = name_q[t];
         e_end     = e_lo_q[t+1];
         for (int i = p_lo_q[t]; i < p_lo_q[t+1]; i++) begin
            @(negedge clk);
            fp_we   = 1'b1;                            // Deposit one word
            fp_addr = cft_pkg::ADDR_W'(p_addr_q[i]);
            fp_data = cft_pkg::DATA_W'(p_data_q[i]);
         end
         @(negedge clk);
         fp_we = 1'b0;
         start = 1'b1;                                 // Run from address 0
         @(negedge clk);
         start = 1'b0;
         check_value("halted after start", 0, int'(halted));
         while (halted !== 1'b1) @(negedge clk);       // End of program
         check_value("output count", e_lo_q[t+1] - e_lo_q[t], e_ptr - e_lo_q[t]);
      end
      $display("sim passed");
      $finish;
   end

endmodule

// File: src/cft_mini.sv
`timescale 1ns/100ps

module cft_mini (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       fp_we,      // Deposit strobe
   input  logic [cft_pkg::ADDR_W-1:0] fp_addr,
   input  logic [cft_pkg::DATA_W-1:0] fp_data,
   input  logic                       start,      // Run from address 0
   output logic                       halted,
   output logic                       out_valid,
   output logic [cft_pkg::DATA_W-1:0] out_data,
   input  logic                       out_credit  // Credit return pulse
);

   // Backplane wiring
   logic                       pc_load, pc_inc, pc_clear;
   logic                       ir_load, ac_load, ac_clear;
   logic                       addr_sel, mem_we, out_req;
   logic                       out_ready, out_sent;
   logic                       ac_zero, ac_neg;
   logic [cft_pkg::ADDR_W-1:0] pc;
   logic [cft_pkg::ADDR_W-1:0] mem_addr;
   logic [cft_pkg::DATA_W-1:0] ir, ac;
   logic [cft_pkg::DATA_W-1:0] mem_rdata, alu_result;

   //////////////////////////////////////////////////
   //
   // THE CTL CARD
   //
   //////////////////////////////////////////////////

   card_ctl card_ctl (
      .clk(clk), .arst_n(arst_n), .start(start), .ir(ir),
      .ac_zero(ac_zero), .ac_neg(ac_neg),
      .out_ready(out_ready), .out_sent(out_sent), .halted(halted),
      .pc_load(pc_load), .pc_inc(pc_inc), .pc_clear(pc_clear),
      .ir_load(ir_load), .ac_load(ac_load), .ac_clear(ac_clear),
      .addr_sel(addr_sel), .mem_we(mem_we), .out_req(out_req)
   );

   //////////////////////////////////////////////////
   //
   // THE REG CARD
   //
   //////////////////////////////////////////////////

   card_reg card_reg (
      .clk(clk), .arst_n(arst_n),
      .pc_load(pc_load), .pc_inc(pc_inc), .pc_clear(pc_clear),
      .ir_load(ir_load), .ac_load(ac_load), .ac_clear(ac_clear),
      .mem_rdata(mem_rdata), .alu_result(alu_result),
      .pc(pc), .ir(ir), .ac(ac)
   );

   //////////////////////////////////////////////////
   //
   // THE ALU CARD
   //
   //////////////////////////////////////////////////

   card_alu card_alu (
      .ir(ir), .ac(ac), .mem_rdata(mem_rdata),
      .alu_result(alu_result), .ac_zero(ac_zero), .ac_neg(ac_neg)
   );

   //////////////////////////////////////////////////
   //
   // THE MEM CARD
   //
   //////////////////////////////////////////////////

   card_mem card_mem (
      .clk(clk), .fp_we(fp_we), .fp_addr(fp_addr), .fp_data(fp_data),
      .halted(halted), .mem_we(mem_we), .mem_addr(mem_addr), .ac(ac),
      .mem_rdata(mem_rdata)
   );

   //////////////////////////////////////////////////
   //
   // THE BUS CARD
   //
   //////////////////////////////////////////////////

   card_bus card_bus (
      .clk(clk), .arst_n(arst_n), .addr_sel(addr_sel), .pc(pc), .ir(ir),
      .out_req(out_req), .ac(ac), .out_credit(out_credit),
      .mem_addr(mem_addr), .out_ready(out_ready), .out_sent(out_sent),
      .out_valid(out_valid), .out_data(out_data)
   );

endmodule

// File: src/card_bus.sv
`timescale 1ns/100ps

module card_bus (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       addr_sel,   // 0 selects PC
   input  logic [cft_pkg::ADDR_W-1:0] pc,
   input  logic [cft_pkg::DATA_W-1:0] ir,
   input  logic                       out_req,
   input  logic [cft_pkg::DATA_W-1:0] ac,
   input  logic                       out_credit, // One credit back
   output logic [cft_pkg::ADDR_W-1:0] mem_addr,
   output logic                       out_ready,
   output logic                       out_sent,
   output logic                       out_valid,
   output logic [cft_pkg::DATA_W-1:0] out_data
);

   logic [cft_pkg::CREDIT_W-1:0] credit_cnt;

   //////////////////////////////////////////////////
   //
   // Address mux
   //
   //////////////////////////////////////////////////

   assign mem_addr = addr_sel ? ir[cft_pkg::ADDR_W-1:0] : pc;

   //////////////////////////////////////////////////
   //
   // Output port
   //
   //////////////////////////////////////////////////

   assign out_ready = (credit_cnt != '0);             // Room at the receiver
   assign out_valid = out_req && out_ready;           // One cycle per word
   assign out_sent  = out_valid;
   assign out_data  = ac;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= cft_pkg::CREDIT_W'(cft_pkg::OUT_CREDITS);
      end else begin
         case ({out_valid, out_credit})
            2'b10:   credit_cnt <= credit_cnt - cft_pkg::CREDIT_W'(1); // Spend
            2'b01:   credit_cnt <= credit_cnt + cft_pkg::CREDIT_W'(1); // Return
            default: credit_cnt <= credit_cnt;        // Both or none cancel
         endcase
      end
   end

   // Receiver never hands back more than it got
   a_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
      credit_cnt <= cft_pkg::OUT_CREDITS);

   a_no_send_dry: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> (credit_cnt != '0));

endmodule

// File: src/card_mem.sv
`timescale 1ns/100ps

module card_mem (
   input  logic                       clk,
   input  logic                       fp_we,      // Front-panel deposit strobe
   input  logic [cft_pkg::ADDR_W-1:0] fp_addr,
   input  logic [cft_pkg::DATA_W-1:0] fp_data,
   input  logic                       halted,     // Gates deposits
   input  logic                       mem_we,     // CPU store
   input  logic [cft_pkg::ADDR_W-1:0] mem_addr,
   input  logic [cft_pkg::DATA_W-1:0] ac,         // Store data
   output logic [cft_pkg::DATA_W-1:0] mem_rdata
);

   logic [cft_pkg::DATA_W-1:0] ram [cft_pkg::MEM_WORDS];

   //////////////////////////////////////////////////
   //
   // Write ports
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (fp_we && halted) begin
         ram[fp_addr] <= fp_data;                     // Deposit while stopped
      end else if (mem_we) begin
         ram[mem_addr] <= ac;                         // STA
      end
   end

   //////////////////////////////////////////////////
   //
   // Registered read
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      mem_rdata <= ram[mem_addr];                     // Data one cycle later
   end

   // The front panel may only deposit into a stopped machine
   a_fp_halted: assert property (@(posedge clk) fp_we |-> halted);

endmodule

// File: src/card_alu.sv
`timescale 1ns/100ps

module card_alu (
   input  logic [cft_pkg::DATA_W-1:0] ir,
   input  logic [cft_pkg::DATA_W-1:0] ac,
   input  logic [cft_pkg::DATA_W-1:0] mem_rdata,   // Operand data
   output logic [cft_pkg::DATA_W-1:0] alu_result,
   output logic                       ac_zero,
   output logic                       ac_neg
);

   cft_pkg::opcode_e op;

   assign op = cft_pkg::opcode_e'(ir[cft_pkg::DATA_W-1 -: cft_pkg::OPCODE_W]);

   //////////////////////////////////////////////////
   //
   // Result select
   //
   //////////////////////////////////////////////////

   always_comb begin
      case (op)
         cft_pkg::op_ldi: begin
            alu_result = {{(cft_pkg::DATA_W - cft_pkg::ADDR_W){1'b0}},
                          ir[cft_pkg::ADDR_W-1:0]};    // Zero-extended immediate
         end
         cft_pkg::op_lda: alu_result = mem_rdata;
         cft_pkg::op_add: alu_result = ac + mem_rdata; // Carry dropped
         cft_pkg::op_and: alu_result = ac & mem_rdata;
         cft_pkg::op_not: alu_result = ~ac;
         default:         alu_result = ac;             // Not loaded by others
      endcase
   end

   //////////////////////////////////////////////////
   //
   // Branch conditions
   //
   //////////////////////////////////////////////////

   assign ac_zero = (ac == '0);
   assign ac_neg  = ac[cft_pkg::DATA_W-1];             // Sign bit

endmodule

// File: src/card_reg.sv
`timescale 1ns/100ps

module card_reg (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       pc_load,     // Jump target from IR
   input  logic                       pc_inc,
   input  logic                       pc_clear,
   input  logic                       ir_load,
   input  logic                       ac_load,
   input  logic                       ac_clear,
   input  logic [cft_pkg::DATA_W-1:0] mem_rdata,
   input  logic [cft_pkg::DATA_W-1:0] alu_result,
   output logic [cft_pkg::ADDR_W-1:0] pc,
   output logic [cft_pkg::DATA_W-1:0] ir,
   output logic [cft_pkg::DATA_W-1:0] ac
);

   //////////////////////////////////////////////////
   //
   // Program counter
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= '0;
      end else if (pc_clear) begin
         pc <= '0;                                    // Start of a run
      end else if (pc_load) begin
         pc <= ir[cft_pkg::ADDR_W-1:0];               // Operand field
      end else if (pc_inc) begin
         pc <= pc + cft_pkg::ADDR_W'(1);              // Wraps at 4096
      end
   end

   //////////////////////////////////////////////////
   //
   // Instruction register
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (ir_load) begin
         ir <= mem_rdata;                             // Word read in fetch
      end
   end

   //////////////////////////////////////////////////
   //
   // Accumulator
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ac <= '0;
      end else if (ac_clear) begin
         ac <= '0;                                    // Fresh AC per run
      end else if (ac_load) begin
         ac <= alu_result;
      end
   end

   // Jumps land in exec, increments in decode
   a_pc_one_src: assert property (@(posedge clk) disable iff (!arst_n)
      !(pc_load && pc_inc));

endmodule

// File: src/card_ctl.sv
`timescale 1ns/100ps

module card_ctl (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       start,      // Run pulse from the front panel
   input  logic [cft_pkg::DATA_W-1:0] ir,
   input  logic                       ac_zero,
   input  logic                       ac_neg,
   input  logic                       out_ready,  // At least one credit held
   input  logic                       out_sent,   // Word left this cycle
   output logic                       halted,
   output logic                       pc_load,
   output logic                       pc_inc,
   output logic                       pc_clear,
   output logic                       ir_load,
   output logic                       ac_load,
   output logic                       ac_clear,
   output logic                       addr_sel,   // 0 selects PC, 1 the operand
   output logic                       mem_we,
   output logic                       out_req
);

   cft_pkg::ctl_state_e state;
   cft_pkg::ctl_state_e state_nxt;
   cft_pkg::opcode_e    op;

   assign op     = cft_pkg::opcode_e'(ir[cft_pkg::DATA_W-1 -: cft_pkg::OPCODE_W]);
   assign halted = (state == cft_pkg::st_halt);

   //////////////////////////////////////////////////
   //
   // State register
   //
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= cft_pkg::st_halt;                   // Come up stopped
      end else begin
         state <= state_nxt;
      end
   end

   //////////////////////////////////////////////////
   //
   // Next state and control strobes
   //
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      pc_load   = 1'b0;
      pc_inc    = 1'b0;
      pc_clear  = 1'b0;
      ir_load   = 1'b0;
      ac_load   = 1'b0;
      ac_clear  = 1'b0;
      addr_sel  = 1'b0;                               // PC unless told otherwise
      mem_we    = 1'b0;
      out_req   = 1'b0;
      case (state)
         cft_pkg::st_halt: begin
            if (start) begin
               pc_clear  = 1'b1;                      // Run always begins at 0
               ac_clear  = 1'b1;
               state_nxt = cft_pkg::st_fetch;
            end
         end
         cft_pkg::st_fetch: begin
            state_nxt = cft_pkg::st_decode;           // Read of mem[PC] issued
         end
         cft_pkg::st_decode: begin
            ir_load   = 1'b1;                         // Instruction on mem_rdata
            pc_inc    = 1'b1;
            state_nxt = cft_pkg::st_exec;
         end
         cft_pkg::st_exec: begin
            state_nxt = cft_pkg::st_fetch;
            case (op)
               cft_pkg::op_ldi,
               cft_pkg::op_not: ac_load = 1'b1;       // ALU result is ready now
               cft_pkg::op_lda,
               cft_pkg::op_add,
               cft_pkg::op_and,
               cft_pkg::op_sta: begin
                  addr_sel  = 1'b1;                   // Operand address out
                  state_nxt = cft_pkg::st_mem;
               end
               cft_pkg::op_jmp: pc_load = 1'b1;
               cft_pkg::op_jz:  pc_load = ac_zero;    // Taken on zero only
               cft_pkg::op_jn:  pc_load = ac_neg;     // Taken on sign bit
               cft_pkg::op_out: state_nxt = cft_pkg::st_out;
               default:         state_nxt = cft_pkg::st_halt; // HLT and unused codes
            endcase
         end
         cft_pkg::st_mem: begin
            addr_sel  = 1'b1;                         // Hold operand address
            state_nxt = cft_pkg::st_fetch;
            if (op == cft_pkg::op_sta) begin
               mem_we = 1'b1;                         // Store AC
            end else begin
               ac_load = 1'b1;                        // Memory data via ALU
            end
         end
         cft_pkg::st_out: begin
            out_req = out_ready;                      // Ask only with a credit
            if (out_sent) begin
               state_nxt = cft_pkg::st_fetch;
            end
         end
         default: state_nxt = cft_pkg::st_halt;
      endcase
   end

   // Fetch and store cycles must never share a memory slot
   a_we_vs_ir: assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_we && ir_load));

endmodule

// File: src/cft_pkg.sv
package cft_pkg;

   //////////////////////////////////////////////////
   //
   // Word and address geometry
   //
   //////////////////////////////////////////////////

   localparam int DATA_W    = 16;            // Data word and instruction width
   localparam int OPCODE_W  = 4;             // Opcode field at the top of the word
   localparam int ADDR_W    = 12;            // Operand field and memory address
   localparam int MEM_WORDS = 4096;          // One full 12-bit page

   //////////////////////////////////////////////////
   //
   // Output port flow control
   //
   //////////////////////////////////////////////////

   localparam int OUT_CREDITS = 2;                       // Credits held after reset
   localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1); // Counter width for 0..OUT_CREDITS

   //////////////////////////////////////////////////
   //
   // Instruction set
   //
   //////////////////////////////////////////////////

   // Codes 11 to 15 are not defined and stop the machine like op_hlt
   typedef enum logic [OPCODE_W-1:0] {
      op_hlt = 4'd0,                         // Stop
      op_ldi = 4'd1,                         // AC = zero-extended operand
      op_lda = 4'd2,                         // AC = mem[operand]
      op_sta = 4'd3,                         // mem[operand] = AC
      op_add = 4'd4,                         // AC = AC + mem[operand] with wrap
      op_and = 4'd5,                         // AC = AC & mem[operand]
      op_not = 4'd6,                         // AC = ~AC
      op_jmp = 4'd7,                         // PC = operand
      op_jz  = 4'd8,                         // Jump if AC is zero
      op_jn  = 4'd9,                         // Jump if AC[15] set
      op_out = 4'd10                         // AC to output port
   } opcode_e;

   //////////////////////////////////////////////////
   //
   // Sequencer states
   //
   //////////////////////////////////////////////////

   typedef enum logic [2:0] {
      st_halt,                               // Idle while the front panel owns memory
      st_fetch,                              // PC on the address bus
      st_decode,                             // Word arrives, latch IR, bump PC
      st_exec,                               // Act on the opcode
      st_mem,                                // Operand data cycle
      st_out                                 // Wait for an output credit
   } ctl_state_e;

endpackage
